// File: mem_subsystem.f
+incdir+.
bus_pkg.sv
memory_bus_ctrl.sv
word_memory.sv
mem_subsystem_top.sv
mem_subsystem_props.sv
mem_subsystem_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build the testbench with verilator, run it and look for the pass line

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 \
   --top-module mem_subsystem_tb \
   -f mem_subsystem.f \
   -o mem_subsystem_sim \
   || { echo "verilator build failed"; exit 1; }

sim_out="$(./obj_dir/mem_subsystem_sim 2>&1)"
echo "$sim_out"

echo "$sim_out" | grep -qx "all tests passed" && exit 0 || exit 1

// File: mem_subsystem_tb.sv
`timescale 1ns/1ps

`include "bus_ctrl_config.svh"

module mem_subsystem_tb
   import bus_pkg::*;
();

   localparam int CLK_HALF       = 4;
   localparam int RESET_CYCLES   = 16;
   localparam int N_RAND_OPS     = 400;
   localparam int CYCLES_PER_OP  = 500;
   localparam int BLOCK_WORDS    = `BLOCK_BITS / `WORD_BITS;
   localparam int BLOCK_BYTES    = BLOCK_WORDS * `WORD_BYTES;
   localparam int N_BLOCKS       = `MEM_WORDS / BLOCK_WORDS;
   localparam int WIDX_BITS      = $clog2(`MEM_WORDS);
   localparam int TIMEOUT_CYCLES = (RESET_CYCLES + N_BLOCKS + N_RAND_OPS) * CYCLES_PER_OP;

   // expected block and the bits of it that are compared
   typedef struct packed {
      logic [`BLOCK_BITS-1:0] data;
      logic [`BLOCK_BITS-1:0] mask;
   } exp_t;

   logic                   clk_i;
   logic                   rstn_i;
   l1_req_t                ic_req_i;
   logic                   ic_req_valid_i;
   logic                   ic_req_ready_o;
   logic [`BLOCK_BITS-1:0] ic_resp_data_o;
   logic                   ic_resp_valid_o;
   logic                   ic_resp_ready_i;
   l1_req_t                dc_req_i;
   logic                   dc_req_valid_i;
   logic                   dc_req_ready_o;
   logic [`BLOCK_BITS-1:0] dc_resp_data_o;
   logic                   dc_resp_valid_o;
   logic                   dc_resp_ready_i;

   logic [`WORD_BITS-1:0]  shadow [`MEM_WORDS];
   exp_t                   ic_exp_q [$];
   exp_t                   dc_exp_q [$];
   bit                     prev_valid [2];
   bit                     prev_ready [2];
   logic [`BLOCK_BITS-1:0] prev_data [2];
   int                     last_seq [2];
   int                     resp_seq;
   int                     checks;
   int                     errors;

   mem_subsystem_top i_dut (
      .clk_i           (clk_i),
      .rstn_i          (rstn_i),
      .ic_req_i        (ic_req_i),
      .ic_req_valid_i  (ic_req_valid_i),
      .ic_req_ready_o  (ic_req_ready_o),
      .ic_resp_data_o  (ic_resp_data_o),
      .ic_resp_valid_o (ic_resp_valid_o),
      .ic_resp_ready_i (ic_resp_ready_i),
      .dc_req_i        (dc_req_i),
      .dc_req_valid_i  (dc_req_valid_i),
      .dc_req_ready_o  (dc_req_ready_o),
      .dc_resp_data_o  (dc_resp_data_o),
      .dc_resp_valid_o (dc_resp_valid_o),
      .dc_resp_ready_i (dc_resp_ready_i)
   );

   bind memory_bus_ctrl mem_subsystem_props i_props (
      .clk_i           (clk_i),
      .rstn_i          (rstn_i),
      .ic_req_ready_i  (ic_req_ready_o),
      .dc_req_ready_i  (dc_req_ready_o),
      .ic_resp_data_i  (ic_resp_data_o),
      .ic_resp_valid_i (ic_resp_valid_o),
      .ic_resp_ready_i (ic_resp_ready_i),
      .dc_resp_data_i  (dc_resp_data_o),
      .dc_resp_valid_i (dc_resp_valid_o),
      .dc_resp_ready_i (dc_resp_ready_i),
      .mem_req_i       (mem_req_o),
      .mem_req_valid_i (mem_req_valid_o),
      .mem_req_ready_i (mem_req_ready_i)
   );

   initial begin
      clk_i = 1'b0;
      forever #CLK_HALF clk_i = ~clk_i;
   end

   initial begin
      repeat (TIMEOUT_CYCLES) @(posedge clk_i);
      $display("timeout: run still busy after %0d cycles", TIMEOUT_CYCLES);
      $display("tests failed");
      $finish;
   end

   function automatic l1_req_t random_req(input logic write, input logic uncached);
      l1_req_t r;
      int      k;
      r.addr = `ADDR_BITS'(($urandom % N_BLOCKS) * BLOCK_BYTES);
      for (k = 0; k < BLOCK_WORDS; k++) begin
         r.wdata[k*`WORD_BITS +: `WORD_BITS] = $urandom;
      end
      r.write    = write;
      r.uncached = uncached;
      return r;
   endfunction

   // apply one request to the shadow memory and queue the expected block of a read
   function automatic void model_op(input logic is_ic, input l1_req_t req);
      exp_t                 e;
      int                   n_words;
      int                   k;
      logic [WIDX_BITS-1:0] idx;
      // the top level forces instruction requests to be cached
      n_words = (!is_ic && req.uncached) ? 1 : BLOCK_WORDS;
      e.data  = '0;
      e.mask  = '0;
      for (k = 0; k < n_words; k++) begin
         idx = WIDX_BITS'(int'(req.addr) / `WORD_BYTES + k);
         if (req.write) begin
            shadow[idx] = req.wdata[k*`WORD_BITS +: `WORD_BITS];
         end else begin
            e.data[k*`WORD_BITS +: `WORD_BITS] = shadow[idx];
            e.mask[k*`WORD_BITS +: `WORD_BITS] = '1;
         end
      end
      if (!req.write) begin
         if (is_ic) begin
            ic_exp_q.push_back(e);
         end else begin
            dc_exp_q.push_back(e);
         end
      end
   endfunction

   task automatic watch_resp(input int p, input logic valid, input logic ready,
                             input logic [`BLOCK_BITS-1:0] data);
      exp_t  e;
      string pname;
      int    pending;
      pname   = (p == 0) ? "ic" : "dc";
      pending = (p == 0) ? ic_exp_q.size() : dc_exp_q.size();
      if (prev_valid[p] && !prev_ready[p]) begin
         checks += 2;
         assert (valid === 1'b1) else begin
            errors++;
            $display("%s response valid dropped while its ready was low", pname);
         end
         assert (data === prev_data[p]) else begin
            errors++;
            $display("CHECK FAILED %s response hold: expected %h actual %h",
                     pname, prev_data[p], data);
         end
      end
      if (prev_valid[p] && prev_ready[p]) begin
         checks++;
         assert (valid !== 1'b1) else begin
            errors++;
            $display("%s response still valid after it was accepted", pname);
         end
      end
      if (valid === 1'b1) begin
         checks++;
         assert (pending > 0) else begin
            errors++;
            $display("%s response valid with no read outstanding on that port", pname);
         end
         if (ready && pending > 0) begin
            if (p == 0) begin
               e = ic_exp_q.pop_front();
            end else begin
               e = dc_exp_q.pop_front();
            end
            checks++;
            assert ((data & e.mask) === (e.data & e.mask)) else begin
               errors++;
               $display("CHECK FAILED %s read: expected %h actual %h",
                        pname, e.data & e.mask, data & e.mask);
            end
            resp_seq++;
            last_seq[p] = resp_seq;
         end
      end
      prev_valid[p] = (valid === 1'b1);
      prev_ready[p] = ready;
      prev_data[p]  = data;
   endtask

   // sample the response ports at the edge and pick new response readies
   task automatic step();
      @(posedge clk_i);
      watch_resp(0, ic_resp_valid_o, ic_resp_ready_i, ic_resp_data_o);
      watch_resp(1, dc_resp_valid_o, dc_resp_ready_i, dc_resp_data_o);
      ic_resp_ready_i <= (($urandom % 4) != 0);
      dc_resp_ready_i <= (($urandom % 4) != 0);
   endtask

   task automatic check_idle(input string name);
      logic [3:0] got;
      got = {ic_req_ready_o, dc_req_ready_o, ic_resp_valid_o, dc_resp_valid_o};
      checks++;
      assert (got === 4'b0000) else begin
         errors++;
         $display("CHECK FAILED %s: expected %b actual %b", name, 4'b0000, got);
      end
   endtask

   task automatic apply_reset();
      int i;
      rstn_i <= 1'b0;
      for (i = 0; i < RESET_CYCLES; i++) begin
         step();
         if (i > 0) begin
            check_idle("outputs in reset");
         end
      end
      rstn_i <= 1'b1;
      step();
      check_idle("outputs after reset");
   endtask

   task automatic run_ops(input logic do_ic, input l1_req_t ic_req,
                          input logic do_dc, input l1_req_t dc_req);
      logic both_reads;
      both_reads = do_ic && do_dc && !ic_req.write && !dc_req.write;
      // instruction side is served first on a collision
      if (do_ic) begin
         model_op(1'b1, ic_req);
      end
      if (do_dc) begin
         model_op(1'b0, dc_req);
      end
      step();
      ic_req_i       <= ic_req;
      ic_req_valid_i <= do_ic;
      dc_req_i       <= dc_req;
      dc_req_valid_i <= do_dc;
      step();
      // each requesting port waits for its own ready
      while ((do_ic && !ic_req_ready_o) || (do_dc && !dc_req_ready_o)) begin
         step();
      end
      ic_req_valid_i <= 1'b0;
      dc_req_valid_i <= 1'b0;
      // ready returns once the block and any held request are finished
      step();
      while (!ic_req_ready_o || !dc_req_ready_o) begin
         step();
      end
      if (both_reads) begin
         checks++;
         assert (last_seq[0] < last_seq[1]) else begin
            errors++;
            $display("data response came before the instruction response of a collision");
         end
      end
   endtask

   task automatic write_all_blocks();
      int      b;
      l1_req_t r;
      for (b = 0; b < N_BLOCKS; b++) begin
         r      = random_req(1'b1, 1'b0);
         r.addr = `ADDR_BITS'(b * BLOCK_BYTES);
         if (($urandom % 2) != 0) begin
            run_ops(1'b1, r, 1'b0, '0);
         end else begin
            run_ops(1'b0, '0, 1'b1, r);
         end
      end
   endtask

   task automatic random_traffic();
      int      ops;
      int      kind;
      l1_req_t ic_r;
      l1_req_t dc_r;
      ops = 0;
      while (ops < N_RAND_OPS) begin
         kind = $urandom % 3;
         // a random uncached flag on ic is dropped by the top level
         ic_r = random_req(1'($urandom % 2), 1'($urandom % 2));
         dc_r = random_req(1'($urandom % 2), ($urandom % 4) == 0);
         case (kind)
            0: begin
               run_ops(1'b1, ic_r, 1'b0, dc_r);
               ops += 1;
            end
            1: begin
               run_ops(1'b0, ic_r, 1'b1, dc_r);
               ops += 1;
            end
            default: begin
               run_ops(1'b1, ic_r, 1'b1, dc_r);
               ops += 2;
            end
         endcase
      end
   endtask

   initial begin
      void'($urandom(32'ha93a));
      rstn_i          = 1'b0;
      ic_req_i        = '0;
      ic_req_valid_i  = 1'b0;
      ic_resp_ready_i = 1'b0;
      dc_req_i        = '0;
      dc_req_valid_i  = 1'b0;
      dc_resp_ready_i = 1'b0;

      apply_reset();
      write_all_blocks();
      random_traffic();

      checks++;
      assert (ic_exp_q.size() == 0 && dc_exp_q.size() == 0) else begin
         errors++;
         $display("reads left without a response: ic %0d dc %0d",
                  ic_exp_q.size(), dc_exp_q.size());
      end

      $display("checks run: %0d, errors: %0d", checks, errors);
      if (errors == 0) begin
         $display("all tests passed");
      end else begin
         $display("tests failed");
      end
      $finish;
   end

endmodule

// File: mem_subsystem_props.sv
`timescale 1ns/1ps

`include "bus_ctrl_config.svh"

module mem_subsystem_props
   import bus_pkg::*;
(
   input logic                   clk_i,
   input logic                   rstn_i,
   input logic                   ic_req_ready_i,
   input logic                   dc_req_ready_i,
   input logic [`BLOCK_BITS-1:0] ic_resp_data_i,
   input logic                   ic_resp_valid_i,
   input logic                   ic_resp_ready_i,
   input logic [`BLOCK_BITS-1:0] dc_resp_data_i,
   input logic                   dc_resp_valid_i,
   input logic                   dc_resp_ready_i,
   input mem_req_t               mem_req_i,
   input logic                   mem_req_valid_i,
   input logic                   mem_req_ready_i
);

   ic_resp_hold: assert property (@(posedge clk_i) disable iff (!rstn_i)
      ic_resp_valid_i && !ic_resp_ready_i |=> ic_resp_valid_i && $stable(ic_resp_data_i))
      else $error("instruction response changed before it was taken");

   dc_resp_hold: assert property (@(posedge clk_i) disable iff (!rstn_i)
      dc_resp_valid_i && !dc_resp_ready_i |=> dc_resp_valid_i && $stable(dc_resp_data_i))
      else $error("data response changed before it was taken");

   // word requests stall in place under memory back-pressure
   mem_req_hold: assert property (@(posedge clk_i) disable iff (!rstn_i)
      mem_req_valid_i && !mem_req_ready_i |=> mem_req_valid_i && $stable(mem_req_i))
      else $error("memory request changed before it was taken");

   resp_onehot: assert property (@(posedge clk_i) disable iff (!rstn_i)
      !(ic_resp_valid_i && dc_resp_valid_i))
      else $error("both response valids high together");

   ready_vs_resp: assert property (@(posedge clk_i) disable iff (!rstn_i)
      !((ic_req_ready_i || dc_req_ready_i) && (ic_resp_valid_i || dc_resp_valid_i)))
      else $error("cache ready high while a response is pending");

endmodule

// File: mem_subsystem_top.sv
`timescale 1ns/1ps

`include "bus_ctrl_config.svh"

module mem_subsystem_top
   import bus_pkg::*;
(
   input  logic                   clk_i,
   input  logic                   rstn_i,

   input  l1_req_t                ic_req_i,
   input  logic                   ic_req_valid_i,
   output logic                   ic_req_ready_o,
   output logic [`BLOCK_BITS-1:0] ic_resp_data_o,
   output logic                   ic_resp_valid_o,
   input  logic                   ic_resp_ready_i,

   input  l1_req_t                dc_req_i,
   input  logic                   dc_req_valid_i,
   output logic                   dc_req_ready_o,
   output logic [`BLOCK_BITS-1:0] dc_resp_data_o,
   output logic                   dc_resp_valid_o,
   input  logic                   dc_resp_ready_i
);

   l1_req_t               ic_req;
   mem_req_t              mem_req;
   logic                  mem_req_valid;
   logic                  mem_req_ready;
   logic [`WORD_BITS-1:0] mem_resp_data;
   logic                  mem_resp_valid;
   logic                  mem_resp_ready;

   // instruction fetches are always cached
   always_comb begin
      ic_req          = ic_req_i;
      ic_req.uncached = 1'b0;
   end

   memory_bus_ctrl i_ctrl (
      .clk_i            (clk_i),
      .rstn_i           (rstn_i),
      .ic_req_i         (ic_req),
      .ic_req_valid_i   (ic_req_valid_i),
      .ic_req_ready_o   (ic_req_ready_o),
      .ic_resp_data_o   (ic_resp_data_o),
      .ic_resp_valid_o  (ic_resp_valid_o),
      .ic_resp_ready_i  (ic_resp_ready_i),
      .dc_req_i         (dc_req_i),
      .dc_req_valid_i   (dc_req_valid_i),
      .dc_req_ready_o   (dc_req_ready_o),
      .dc_resp_data_o   (dc_resp_data_o),
      .dc_resp_valid_o  (dc_resp_valid_o),
      .dc_resp_ready_i  (dc_resp_ready_i),
      .mem_req_o        (mem_req),
      .mem_req_valid_o  (mem_req_valid),
      .mem_req_ready_i  (mem_req_ready),
      .mem_resp_data_i  (mem_resp_data),
      .mem_resp_valid_i (mem_resp_valid),
      .mem_resp_ready_o (mem_resp_ready)
   );

   word_memory #(
      .MEM_DEPTH (`MEM_WORDS)
   ) i_mem (
      .clk_i        (clk_i),
      .rstn_i       (rstn_i),
      .req_i        (mem_req),
      .req_valid_i  (mem_req_valid),
      .req_ready_o  (mem_req_ready),
      .resp_data_o  (mem_resp_data),
      .resp_valid_o (mem_resp_valid),
      .resp_ready_i (mem_resp_ready)
   );

endmodule

// File: word_memory.sv
`timescale 1ns/1ps

`include "bus_ctrl_config.svh"

module word_memory
   import bus_pkg::*;
#(
   parameter int MEM_DEPTH = `MEM_WORDS
) (
   input  logic                  clk_i,
   input  logic                  rstn_i,

   input  mem_req_t              req_i,
   input  logic                  req_valid_i,
   output logic                  req_ready_o,

   output logic [`WORD_BITS-1:0] resp_data_o,
   output logic                  resp_valid_o,
   input  logic                  resp_ready_i
);

   localparam int IDX_BITS = $clog2(MEM_DEPTH);
   localparam int OFS_BITS = $clog2(`WORD_BYTES);

   logic [`WORD_BITS-1:0] mem_r [MEM_DEPTH];
   logic [`WORD_BITS-1:0] buf_r [2];

   logic                  wr_ptr_r;
   logic                  rd_ptr_r;
   logic [1:0]            cnt_r;
   logic [IDX_BITS-1:0]   word_idx;
   logic                  req_fire;
   logic                  push;
   logic                  pop;

   assign word_idx     = req_i.addr[OFS_BITS +: IDX_BITS];
   assign resp_valid_o = (cnt_r != 2'd0);
   assign resp_data_o  = buf_r[rd_ptr_r];
   assign pop          = resp_valid_o & resp_ready_i;

   // a full buffer still takes a read if a word leaves this cycle
   assign req_ready_o  = (cnt_r != 2'd2) | pop;
   assign req_fire     = req_valid_i & req_ready_o;
   assign push         = req_fire & ~req_i.write;

   always_ff @(posedge clk_i) begin
      if (req_fire && req_i.write) begin
         mem_r[word_idx] <= req_i.wdata;
      end
      if (push) begin
         buf_r[wr_ptr_r] <= mem_r[word_idx];
      end
   end

   always_ff @(posedge clk_i) begin
      if (!rstn_i) begin
         wr_ptr_r <= 1'b0;
         rd_ptr_r <= 1'b0;
         cnt_r    <= 2'd0;
      end else begin
         if (push) begin
            wr_ptr_r <= ~wr_ptr_r;
         end
         if (pop) begin
            rd_ptr_r <= ~rd_ptr_r;
         end
         case ({push, pop})
            2'b10:   cnt_r <= cnt_r + 2'd1;
            2'b01:   cnt_r <= cnt_r - 2'd1;
            default: cnt_r <= cnt_r;
         endcase
      end
   end

endmodule

// File: memory_bus_ctrl.sv
`timescale 1ns/1ps

`include "bus_ctrl_config.svh"

module memory_bus_ctrl
   import bus_pkg::*;
(
   input  logic                   clk_i,
   input  logic                   rstn_i,

   // instruction cache
   input  l1_req_t                ic_req_i,
   input  logic                   ic_req_valid_i,
   output logic                   ic_req_ready_o,
   output logic [`BLOCK_BITS-1:0] ic_resp_data_o,
   output logic                   ic_resp_valid_o,
   input  logic                   ic_resp_ready_i,

   // data cache
   input  l1_req_t                dc_req_i,
   input  logic                   dc_req_valid_i,
   output logic                   dc_req_ready_o,
   output logic [`BLOCK_BITS-1:0] dc_resp_data_o,
   output logic                   dc_resp_valid_o,
   input  logic                   dc_resp_ready_i,

   // word memory
   output mem_req_t               mem_req_o,
   output logic                   mem_req_valid_o,
   input  logic                   mem_req_ready_i,
   input  logic [`WORD_BITS-1:0]  mem_resp_data_i,
   input  logic                   mem_resp_valid_i,
   output logic                   mem_resp_ready_o
);

   localparam int BLOCK_WORDS = `BLOCK_BITS / `WORD_BITS;
   localparam int IDX_BITS    = $clog2(BLOCK_WORDS);

   typedef enum logic [2:0] {
      ST_IDLE,
      ST_RD_ISSUE,
      ST_RD_DRAIN,
      ST_RESP,
      ST_WRITE,
      ST_SECOND
   } state_t;

   state_t                 state_r;
   state_t                 state_ns;

   logic                   req_ready_r;
   logic                   req_ready_ns;
   logic                   sel_ic_r;
   logic                   sel_ic_ns;
   logic                   resp_valid_r;
   logic                   resp_valid_ns;
   logic                   mem_valid_r;
   logic                   mem_valid_ns;
   logic                   mem_resp_ready_r;
   logic                   mem_resp_ready_ns;
   logic                   pend_valid_r;
   logic                   pend_valid_ns;

   l1_req_t                pend_req_r;
   l1_req_t                pend_req_ns;
   mem_req_t               mem_req_r;
   mem_req_t               mem_req_ns;
   logic [`BLOCK_BITS-1:0] blk_r;
   logic [`BLOCK_BITS-1:0] blk_ns;

   logic [IDX_BITS-1:0]    issue_idx_r;
   logic [IDX_BITS-1:0]    issue_idx_ns;
   logic [IDX_BITS-1:0]    coll_idx_r;
   logic [IDX_BITS-1:0]    coll_idx_ns;
   logic [IDX_BITS-1:0]    last_idx_r;
   logic [IDX_BITS-1:0]    last_idx_ns;

   logic                   ic_fire;
   logic                   dc_fire;
   logic                   launch;
   logic                   resp_ready;
   l1_req_t                start_req;

   // ready is shared, so a valid on either port is a transfer
   assign ic_fire    = req_ready_r & ic_req_valid_i;
   assign dc_fire    = req_ready_r & dc_req_valid_i;
   assign launch     = ic_fire | dc_fire | (state_r == ST_SECOND);
   assign resp_ready = sel_ic_r ? ic_resp_ready_i : dc_resp_ready_i;

   // instruction side wins, held data request goes after it
   always_comb begin
      if (state_r == ST_SECOND) begin
         start_req = pend_req_r;
      end else if (ic_fire) begin
         start_req = ic_req_i;
      end else begin
         start_req = dc_req_i;
      end
   end

   always_comb begin
      state_ns          = state_r;
      sel_ic_ns         = sel_ic_r;
      resp_valid_ns     = resp_valid_r;
      mem_valid_ns      = mem_valid_r;
      mem_resp_ready_ns = mem_resp_ready_r;
      pend_valid_ns     = pend_valid_r;
      pend_req_ns       = pend_req_r;
      mem_req_ns        = mem_req_r;
      blk_ns            = blk_r;
      issue_idx_ns      = issue_idx_r;
      coll_idx_ns       = coll_idx_r;
      last_idx_ns       = last_idx_r;

      if (launch) begin
         sel_ic_ns         = ic_fire;
         pend_valid_ns     = ic_fire & dc_fire;
         if (ic_fire && dc_fire) begin
            pend_req_ns = dc_req_i;
         end
         mem_req_ns.addr   = start_req.addr;
         mem_req_ns.wdata  = start_req.wdata[`WORD_BITS-1:0];
         mem_req_ns.write  = start_req.write;
         mem_valid_ns      = 1'b1;
         mem_resp_ready_ns = ~start_req.write;
         blk_ns            = start_req.wdata;
         issue_idx_ns      = '0;
         coll_idx_ns       = '0;
         last_idx_ns       = start_req.uncached ? IDX_BITS'(0) : IDX_BITS'(BLOCK_WORDS - 1);
         state_ns          = start_req.write ? ST_WRITE : ST_RD_ISSUE;
      end

      case (state_r)
         ST_RD_ISSUE, ST_WRITE: begin
            if (mem_valid_r && mem_req_ready_i) begin
               issue_idx_ns     = issue_idx_r + 1'b1;
               mem_req_ns.addr  = mem_req_r.addr + `ADDR_BITS'(`WORD_BYTES);
               mem_req_ns.wdata = blk_r[issue_idx_ns * `WORD_BITS +: `WORD_BITS];
               if (issue_idx_r == last_idx_r) begin
                  mem_valid_ns = 1'b0;
                  if (state_r == ST_WRITE) begin
                     // writes finish once the last word is taken
                     state_ns = pend_valid_r ? ST_SECOND : ST_IDLE;
                  end else begin
                     state_ns = ST_RD_DRAIN;
                  end
               end
            end
         end
         ST_RESP: begin
            if (resp_valid_r && resp_ready) begin
               resp_valid_ns = 1'b0;
               state_ns      = pend_valid_r ? ST_SECOND : ST_IDLE;
            end
         end
         default: begin
         end
      endcase

      // collect read words, runs alongside issue
      if (mem_resp_ready_r && mem_resp_valid_i) begin
         blk_ns[coll_idx_r * `WORD_BITS +: `WORD_BITS] = mem_resp_data_i;
         coll_idx_ns = coll_idx_r + 1'b1;
         if (coll_idx_r == last_idx_r) begin
            mem_resp_ready_ns = 1'b0;
            resp_valid_ns     = 1'b1;
            state_ns          = ST_RESP;
         end
      end

      req_ready_ns = (state_ns == ST_IDLE);
   end

   always_ff @(posedge clk_i) begin
      if (!rstn_i) begin
         state_r          <= ST_IDLE;
         req_ready_r      <= 1'b0;
         sel_ic_r         <= 1'b0;
         resp_valid_r     <= 1'b0;
         mem_valid_r      <= 1'b0;
         mem_resp_ready_r <= 1'b0;
         pend_valid_r     <= 1'b0;
         issue_idx_r      <= '0;
         coll_idx_r       <= '0;
         last_idx_r       <= '0;
      end else begin
         state_r          <= state_ns;
         req_ready_r      <= req_ready_ns;
         sel_ic_r         <= sel_ic_ns;
         resp_valid_r     <= resp_valid_ns;
         mem_valid_r      <= mem_valid_ns;
         mem_resp_ready_r <= mem_resp_ready_ns;
         pend_valid_r     <= pend_valid_ns;
         issue_idx_r      <= issue_idx_ns;
         coll_idx_r       <= coll_idx_ns;
         last_idx_r       <= last_idx_ns;
      end
   end

   always_ff @(posedge clk_i) begin
      pend_req_r <= pend_req_ns;
      mem_req_r  <= mem_req_ns;
      blk_r      <= blk_ns;
   end

   assign ic_req_ready_o   = req_ready_r;
   assign dc_req_ready_o   = req_ready_r;

   // block buffer doubles as the response data
   assign ic_resp_data_o   = blk_r;
   assign dc_resp_data_o   = blk_r;
   assign ic_resp_valid_o  = resp_valid_r & sel_ic_r;
   assign dc_resp_valid_o  = resp_valid_r & ~sel_ic_r;

   assign mem_req_o        = mem_req_r;
   assign mem_req_valid_o  = mem_valid_r;
   assign mem_resp_ready_o = mem_resp_ready_r;

endmodule

// File: bus_pkg.sv
`include "bus_ctrl_config.svh"

package bus_pkg;

   // block request from a cache, address is block aligned
   typedef struct packed {
      logic [`ADDR_BITS-1:0]  addr;
      logic [`BLOCK_BITS-1:0] wdata;
      logic                   write;
      // only the first word of the block moves
      logic                   uncached;
   } l1_req_t;

   // single word request toward memory
   typedef struct packed {
      logic [`ADDR_BITS-1:0] addr;
      logic [`WORD_BITS-1:0] wdata;
      logic                  write;
   } mem_req_t;

endpackage

// File: bus_ctrl_config.svh
`ifndef BUS_CTRL_CONFIG_SVH
`define BUS_CTRL_CONFIG_SVH

// byte address width
`define ADDR_BITS 32

// memory word width and its size in bytes
`define WORD_BITS 32
`define WORD_BYTES 4

// one cache block is four memory words
`define BLOCK_BITS 128

// memory depth in words
`define MEM_WORDS 256

`endif
